/* sim.f */
+incdir+verif
source/rvfi_trace_pkg.sv
source/csr_map_pkg.sv
source/retire_stage.sv
source/csr_write_route.sv
source/csr_shadow_lane.sv
source/csr_collect.sv
source/nmi_tracker.sv
source/rvvi_trace_top.sv
verif/rvvi_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the trace adapter testbench, nonzero exit on any failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module rvvi_trace_tb -Mdir "$OBJ" -f sim.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$OBJ/Vrvvi_trace_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   echo "FAIL: see $LOG"
   exit 1
fi

echo "PASS"
exit 0

/* verif/trace_ref.svh */
// Included in the testbench module body after the package imports; needs err_cnt, chk_cnt, lfsr_state
`ifndef TRACE_REF_SVH
`define TRACE_REF_SVH

//////////////////////////////////////////////////
// Reference model

// Bit of rd, nothing for x0 or a bubble
function automatic gpr_mask_t onehot_ref(logic valid, gpr_idx_t rd);
   gpr_mask_t m;
   m = '0;
   if (valid && (rd != '0)) begin
      m[rd] = 1'b1;
   end
   return m;
endfunction

// Bit by bit, mask picks new data
function automatic xlen_t csr_update_ref(xlen_t old, xlen_t data, xlen_t mask);
   xlen_t r;
   for (int b = 0; b < XLEN; b++) begin
      r[b] = mask[b] ? data[b] : old[b];
   end
   return r;
endfunction

function automatic nmi_cause_t nmi_cause_ref(logic is_store);
   return is_store ? NMI_CAUSE_STORE : NMI_CAUSE_LOAD;
endfunction

// Table search for a CSR address
function automatic logic find_lane(csr_addr_t addr, output lane_idx_t lane);
   logic hit;
   hit = 1'b0;
   lane = '0;
   for (int i = 0; i < NUM_CSR_LANES; i++) begin
      if (LANE_ADDR[i] == addr) begin
         hit = 1'b1;
         lane = lane_idx_t'(i);
      end
   end
   return hit;
endfunction

//////////////////////////////////////////////////
// Random source

// Galois LFSR, x^32+x^22+x^2+x+1, one step per bit
function automatic logic [31:0] rand_bits(int unsigned n);
   logic [31:0] r;
   r = '0;
   for (int unsigned i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
   end
   return r;
endfunction

//////////////////////////////////////////////////
// Typed compares

task automatic check_flag(string what, logic got, logic exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_order(string what, order_t got, order_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_gpr_mask(string what, gpr_mask_t got, gpr_mask_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_word(string what, xlen_t got, xlen_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_lane_mask(string what, lane_mask_t got, lane_mask_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_cause(string what, nmi_cause_t got, nmi_cause_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
   end
endtask

`endif

/* verif/rvvi_trace_tb.sv */
// Self-checking testbench for rvvi_trace_top; LSU_DEPTH 4, bus responses in request order
module rvvi_trace_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import rvfi_trace_pkg::*;
   import csr_map_pkg::*;

   //////////////////////////////////////////////////
   // Run constants

   localparam int          LSU_DEPTH  = 4;
   localparam logic [31:0] SEED       = 32'h0fed_73c8;
   // Crosses the 32-bit carry of the order counter
   localparam order_t      ORDER_BASE = 64'h0000_0000_ffff_ff80;
   localparam int          L_RET      = 120;
   localparam int          L_GPR      = 120;
   localparam int          L_CSR      = 150;
   localparam int          L_MISS     = 40;
   localparam int          L_NMI      = 200;
   localparam int          L_UF       = 30;
   localparam int          GAP        = 4;
   localparam int          CYCLE_LIMIT = L_RET + L_GPR + L_CSR + L_MISS + L_NMI + L_UF + 50;

   // Expected output record, one per input cycle
   typedef struct packed {
      logic      valid;
      order_t    order;
      xlen_t     insn;
      logic      trap;
      xlen_t     pc_rdata;
      xlen_t     pc_wdata;
      gpr_mask_t wb;
      xlen_t     wdata;
      logic      csr_we;
      logic      csr_hit;
      lane_idx_t lane;
      xlen_t     cdata;
      xlen_t     cmask;
   } rec_t;

   logic       rvvi;
   logic       rst_n_i;
   logic       rvfi_valid_i;
   order_t     rvfi_order_i;
   xlen_t      rvfi_insn_i;
   logic       rvfi_trap_i;
   xlen_t      rvfi_pc_rdata_i;
   xlen_t      rvfi_pc_wdata_i;
   gpr_idx_t   rvfi_rd_addr_i;
   xlen_t      rvfi_rd_wdata_i;
   logic       csr_we_i;
   csr_addr_t  csr_addr_i;
   xlen_t      csr_wdata_i;
   xlen_t      csr_wmask_i;
   lane_idx_t  csr_rd_sel_i;
   logic       data_req_i;
   logic       data_we_i;
   logic       data_rvalid_i;
   logic       data_err_i;
   logic       rvvi_valid_o;
   order_t     rvvi_order_o;
   xlen_t      rvvi_insn_o;
   logic       rvvi_trap_o;
   xlen_t      rvvi_pc_rdata_o;
   xlen_t      rvvi_pc_wdata_o;
   gpr_mask_t  rvvi_x_wb_o;
   xlen_t      rvvi_x_wdata_o;
   lane_mask_t csr_wb_o;
   lane_mask_t csr_written_o;
   xlen_t      csr_rdata_o;
   logic       csr_miss_o;
   logic       nmi_o;
   nmi_cause_t nmi_cause_o;
   logic       ldst_underflow_o;

   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          err_mark = 0;
   int          n_test = 0;
   int          n_fail = 0;
   int          cyc = 0;
   logic [31:0] lfsr_state;
   order_t      order_next;

   `include "trace_ref.svh"

   rvvi_trace_top #(.LSU_DEPTH(LSU_DEPTH)) i_dut (.*);

   initial begin
      rvvi = 1'b0;
      forever #5 rvvi = ~rvvi;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers

   task automatic drive_idle();
      rvfi_valid_i  <= 1'b0;
      csr_we_i      <= 1'b0;
      data_req_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      data_err_i    <= 1'b0;
   endtask

   // Random record, order only steps on valid ones
   task automatic drive_record(logic valid, gpr_idx_t rd);
      rvfi_valid_i <= valid;
      if (valid) begin
         rvfi_order_i <= order_next;
         order_next = order_next + 64'd1;
      end
      rvfi_insn_i     <= xlen_t'(rand_bits(32));
      rvfi_trap_i     <= 1'(rand_bits(1));
      rvfi_pc_rdata_i <= xlen_t'(rand_bits(32));
      rvfi_pc_wdata_i <= xlen_t'(rand_bits(32));
      rvfi_rd_addr_i  <= rd;
      rvfi_rd_wdata_i <= xlen_t'(rand_bits(32));
   endtask

   task automatic drive_csr(logic we, csr_addr_t addr, xlen_t mask);
      csr_we_i     <= we;
      csr_addr_i   <= addr;
      csr_wdata_i  <= xlen_t'(rand_bits(32));
      csr_wmask_i  <= mask;
      csr_rd_sel_i <= lane_idx_t'(rand_bits(3));
   endtask

   // Idle gap lets the pipeline drain before the verdict
   task automatic close_test(string name);
      @(posedge rvvi);
      drive_idle();
      repeat (GAP) @(posedge rvvi);
      n_test++;
      if (err_cnt != err_mark) begin
         n_fail++;
         $display("Test %0d %s: FAIL, %0d errors", n_test, name, err_cnt - err_mark);
      end else begin
         $display("Test %0d %s: PASS", n_test, name);
      end
      err_mark = err_cnt;
   endtask

   //////////////////////////////////////////////////
   // Stimulus

   initial begin : stim
      gpr_idx_t  rd;
      logic      valid;
      csr_addr_t addr;
      lane_idx_t lane;
      xlen_t     mask;
      int        outstanding;
      logic      do_rsp;
      logic      do_req;
      lfsr_state = SEED;
      order_next = ORDER_BASE;
      outstanding = 0;
      rst_n_i         <= 1'b0;
      rvfi_order_i    <= '0;
      rvfi_insn_i     <= '0;
      rvfi_trap_i     <= 1'b0;
      rvfi_pc_rdata_i <= '0;
      rvfi_pc_wdata_i <= '0;
      rvfi_rd_addr_i  <= '0;
      rvfi_rd_wdata_i <= '0;
      csr_addr_i      <= '0;
      csr_wdata_i     <= '0;
      csr_wmask_i     <= '0;
      csr_rd_sel_i    <= '0;
      data_we_i       <= 1'b0;
      drive_idle();
      repeat (2) @(posedge rvvi);
      rst_n_i <= 1'b1;

      // Back-to-back retirements
      for (int i = 0; i < L_RET; i++) begin
         @(posedge rvvi);
         drive_record(1'b1, gpr_idx_t'(rand_bits(5)));
      end
      close_test("retirement stream");

      // Bubbles and frequent x0 targets
      for (int i = 0; i < L_GPR; i++) begin
         @(posedge rvvi);
         valid = (rand_bits(2) != 32'd0);
         rd = (rand_bits(2) == 32'd0) ? '0 : gpr_idx_t'(rand_bits(5));
         drive_record(valid, rd);
      end
      close_test("gpr writeback decode");

      // Tracked addresses, some empty masks
      for (int i = 0; i < L_CSR; i++) begin
         @(posedge rvvi);
         addr = LANE_ADDR[lane_idx_t'(rand_bits(3))];
         mask = (rand_bits(2) == 32'd0) ? '0 : xlen_t'(rand_bits(32));
         drive_csr(rand_bits(3) != 32'd0, addr, mask);
      end
      close_test("masked csr writes");

      for (int i = 0; i < L_MISS; i++) begin
         @(posedge rvvi);
         do begin
            addr = csr_addr_t'(rand_bits(12));
         end while (find_lane(addr, lane));
         drive_csr(1'b1, addr, xlen_t'(rand_bits(32)) | 32'h1);
      end
      close_test("untracked csr address");

      // Queue never overfilled, a pop frees a slot in the same cycle
      for (int i = 0; i < L_NMI; i++) begin
         @(posedge rvvi);
         do_rsp = (outstanding > 0) && (rand_bits(1) != 32'd0);
         do_req = ((outstanding < LSU_DEPTH) || do_rsp) && (rand_bits(1) != 32'd0);
         data_rvalid_i <= do_rsp;
         data_err_i    <= do_rsp && (rand_bits(2) == 32'd0);
         data_req_i    <= do_req;
         data_we_i     <= 1'(rand_bits(1));
         outstanding = outstanding + int'(do_req) - int'(do_rsp);
      end
      while (outstanding > 0) begin
         @(posedge rvvi);
         data_req_i    <= 1'b0;
         data_rvalid_i <= 1'b1;
         data_err_i    <= (rand_bits(2) == 32'd0);
         outstanding--;
      end
      close_test("nmi cause");

      // Responses with nothing outstanding
      for (int i = 0; i < L_UF; i++) begin
         @(posedge rvvi);
         data_req_i    <= 1'b0;
         data_err_i    <= 1'b0;
         data_rvalid_i <= ((i % 3) == 0);
      end
      close_test("queue underflow");

      $display("Checks: %0d, errors: %0d, tests failed: %0d of %0d",
         chk_cnt, err_cnt, n_fail, n_test);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   //////////////////////////////////////////////////
   // Comparison, sampled at the falling edge

   initial begin : compare
      rec_t       exp_q [$];
      rec_t       cur;
      rec_t       e;
      lane_idx_t  lane;
      lane_mask_t exp_wb;
      lane_mask_t exp_written;
      xlen_t      shadow [NUM_CSR_LANES];
      order_t     exp_order;
      logic       store_q [$];
      logic       bus_pend;
      logic       exp_nmi;
      logic       exp_uf;
      nmi_cause_t exp_cause;
      logic       popped;
      exp_written = '0;
      exp_order = ORDER_BASE;
      bus_pend = 1'b0;
      exp_nmi = 1'b0;
      exp_uf = 1'b0;
      exp_cause = '0;
      for (int i = 0; i < NUM_CSR_LANES; i++) begin
         shadow[i] = LANE_RESET[i];
      end
      wait (rst_n_i === 1'b1);
      forever begin
         @(negedge rvvi);
         // This cycle's inputs, due at the outputs 2 cycles on
         cur.valid    = rvfi_valid_i;
         cur.order    = rvfi_order_i;
         cur.insn     = rvfi_insn_i;
         cur.trap     = rvfi_trap_i;
         cur.pc_rdata = rvfi_pc_rdata_i;
         cur.pc_wdata = rvfi_pc_wdata_i;
         cur.wb       = onehot_ref(rvfi_valid_i, rvfi_rd_addr_i);
         cur.wdata    = rvfi_rd_wdata_i;
         cur.csr_we   = csr_we_i;
         cur.csr_hit  = find_lane(csr_addr_i, lane);
         cur.lane     = lane;
         cur.cdata    = csr_wdata_i;
         cur.cmask    = csr_wmask_i;
         exp_q.push_back(cur);

         // Miss flag is one cycle behind
         if (exp_q.size() >= 2) begin
            e = exp_q[exp_q.size() - 2];
            check_flag("csr_miss", csr_miss_o, e.csr_we && !e.csr_hit);
         end

         if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            check_flag("rvvi_valid", rvvi_valid_o, e.valid);
            check_gpr_mask("rvvi_x_wb", rvvi_x_wb_o, e.wb);
            if (e.valid) begin
               check_order("rvvi_order", rvvi_order_o, e.order);
               check_order("order step", rvvi_order_o, exp_order);
               exp_order = exp_order + 64'd1;
               check_word("rvvi_insn", rvvi_insn_o, e.insn);
               check_flag("rvvi_trap", rvvi_trap_o, e.trap);
               check_word("rvvi_pc_rdata", rvvi_pc_rdata_o, e.pc_rdata);
               check_word("rvvi_pc_wdata", rvvi_pc_wdata_o, e.pc_wdata);
               check_word("rvvi_x_wdata", rvvi_x_wdata_o, e.wdata);
            end
            // Sticky mask lags the strobe by a cycle
            exp_wb = '0;
            if (e.csr_we && e.csr_hit && (e.cmask != '0)) begin
               exp_wb[e.lane] = 1'b1;
            end
            check_lane_mask("csr_wb", csr_wb_o, exp_wb);
            check_lane_mask("csr_written", csr_written_o, exp_written);
            exp_written = exp_written | exp_wb;
            if (e.csr_we && e.csr_hit) begin
               shadow[e.lane] = csr_update_ref(shadow[e.lane], e.cdata, e.cmask);
            end
            check_word("csr_rdata", csr_rdata_o, shadow[csr_rd_sel_i]);
         end

         // Bus flags from the previous cycle
         if (bus_pend) begin
            check_flag("nmi", nmi_o, exp_nmi);
            check_flag("ldst_underflow", ldst_underflow_o, exp_uf);
            if (exp_nmi) begin
               check_cause("nmi_cause", nmi_cause_o, exp_cause);
            end
         end
         exp_nmi = data_rvalid_i && data_err_i;
         exp_uf = data_rvalid_i && (store_q.size() == 0);
         popped = 1'b0;
         // Head leaves before this cycle's request joins
         if (data_rvalid_i && (store_q.size() != 0)) begin
            popped = store_q.pop_front();
         end
         exp_cause = nmi_cause_ref(popped);
         if (data_req_i) begin
            store_q.push_back(data_we_i);
         end
         bus_pend = 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Run limit

   initial begin : watchdog
      while (cyc < CYCLE_LIMIT) begin
         @(posedge rvvi);
         cyc++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
   end

endmodule

/* source/rvvi_trace_top.sv */
// Observe-only adapter: every input is sampled each cycle and nothing stalls the core
module rvvi_trace_top #(
   parameter int unsigned LSU_DEPTH = 4
) (
   input  logic                       rvvi,
   input  logic                       rst_n_i,
   // RVFI retirement
   input  logic                       rvfi_valid_i,
   input  rvfi_trace_pkg::order_t     rvfi_order_i,
   input  rvfi_trace_pkg::xlen_t      rvfi_insn_i,
   input  logic                       rvfi_trap_i,
   input  rvfi_trace_pkg::xlen_t      rvfi_pc_rdata_i,
   input  rvfi_trace_pkg::xlen_t      rvfi_pc_wdata_i,
   input  rvfi_trace_pkg::gpr_idx_t   rvfi_rd_addr_i,
   input  rvfi_trace_pkg::xlen_t      rvfi_rd_wdata_i,
   // CSR write
   input  logic                       csr_we_i,
   input  csr_map_pkg::csr_addr_t     csr_addr_i,
   input  rvfi_trace_pkg::xlen_t      csr_wdata_i,
   input  rvfi_trace_pkg::xlen_t      csr_wmask_i,
   input  csr_map_pkg::lane_idx_t     csr_rd_sel_i,
   // Data bus
   input  logic                       data_req_i,
   input  logic                       data_we_i,
   input  logic                       data_rvalid_i,
   input  logic                       data_err_i,
   // RVVI outputs
   output logic                       rvvi_valid_o,
   output rvfi_trace_pkg::order_t     rvvi_order_o,
   output rvfi_trace_pkg::xlen_t      rvvi_insn_o,
   output logic                       rvvi_trap_o,
   output rvfi_trace_pkg::xlen_t      rvvi_pc_rdata_o,
   output rvfi_trace_pkg::xlen_t      rvvi_pc_wdata_o,
   output rvfi_trace_pkg::gpr_mask_t  rvvi_x_wb_o,
   output rvfi_trace_pkg::xlen_t      rvvi_x_wdata_o,
   output csr_map_pkg::lane_mask_t    csr_wb_o,
   output csr_map_pkg::lane_mask_t    csr_written_o,
   output rvfi_trace_pkg::xlen_t      csr_rdata_o,
   output logic                       csr_miss_o,
   output logic                       nmi_o,
   output rvfi_trace_pkg::nmi_cause_t nmi_cause_o,
   output logic                       ldst_underflow_o
);
   import rvfi_trace_pkg::*;
   import csr_map_pkg::*;

   lane_mask_t                    lane_we;
   xlen_t                         lane_wdata;
   xlen_t                         lane_wmask;
   lane_mask_t                    lane_wb;
   xlen_t [NUM_CSR_LANES-1:0]     lane_value;

   //////////////////////////////////////////////////
   // Retirement path

   retire_stage i_retire (
      .rvvi, .rst_n_i,
      .rvfi_valid_i, .rvfi_order_i, .rvfi_insn_i, .rvfi_trap_i,
      .rvfi_pc_rdata_i, .rvfi_pc_wdata_i, .rvfi_rd_addr_i, .rvfi_rd_wdata_i,
      .rvvi_valid_o, .rvvi_order_o, .rvvi_insn_o, .rvvi_trap_o,
      .rvvi_pc_rdata_o, .rvvi_pc_wdata_o, .rvvi_x_wb_o, .rvvi_x_wdata_o
   );

   //////////////////////////////////////////////////
   // CSR path

   csr_write_route i_route (
      .rvvi, .rst_n_i,
      .csr_we_i, .csr_addr_i, .csr_wdata_i, .csr_wmask_i,
      .lane_we_o    (lane_we),
      .lane_wdata_o (lane_wdata),
      .lane_wmask_o (lane_wmask),
      .csr_miss_o
   );

   // One shadow per table entry
   for (genvar gi = 0; gi < NUM_CSR_LANES; gi++) begin : g_lane
      csr_shadow_lane #(
         .LANE_ADDR   (LANE_ADDR[gi]),
         .RESET_VALUE (LANE_RESET[gi])
      ) i_lane (
         .rvvi, .rst_n_i,
         .we_i    (lane_we[gi]),
         .wdata_i (lane_wdata),
         .wmask_i (lane_wmask),
         .value_o (lane_value[gi]),
         .wb_o    (lane_wb[gi])
      );
   end

   csr_collect i_collect (
      .rvvi, .rst_n_i,
      .lane_wb_i    (lane_wb),
      .lane_value_i (lane_value),
      .csr_rd_sel_i, .csr_wb_o, .csr_written_o, .csr_rdata_o
   );

   //////////////////////////////////////////////////
   // Data bus NMI

   nmi_tracker #(.LSU_DEPTH(LSU_DEPTH)) i_nmi (
      .rvvi, .rst_n_i,
      .data_req_i, .data_we_i, .data_rvalid_i, .data_err_i,
      .nmi_o, .nmi_cause_o, .ldst_underflow_o
   );

endmodule

/* source/nmi_tracker.sv */
// Responses must return in request order; no more than LSU_DEPTH requests outstanding
module nmi_tracker #(
   parameter int unsigned LSU_DEPTH = 4
) (
   input  logic                       rvvi,
   input  logic                       rst_n_i,
   input  logic                       data_req_i,
   input  logic                       data_we_i,
   input  logic                       data_rvalid_i,
   input  logic                       data_err_i,
   output logic                       nmi_o,
   output rvfi_trace_pkg::nmi_cause_t nmi_cause_o,
   output logic                       ldst_underflow_o
);
   import rvfi_trace_pkg::*;

   localparam int unsigned PTR_W = (LSU_DEPTH > 1) ? $clog2(LSU_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(LSU_DEPTH + 1);

   // Store flag per outstanding request
   logic [LSU_DEPTH-1:0] store_q;
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;
   logic                 empty;
   logic                 full;
   logic                 push;
   logic                 pop;

   function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(LSU_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(LSU_DEPTH));
   // Full queue still takes a push when the head leaves
   assign push  = data_req_i && (!full || pop);
   assign pop   = data_rvalid_i && !empty;

   //////////////////////////////////////////////////
   // Queue control

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge rvvi) begin
      if (push) begin
         store_q[wr_ptr] <= data_we_i;
      end
   end

   //////////////////////////////////////////////////
   // NMI and underflow flags

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         nmi_o            <= 1'b0;
         ldst_underflow_o <= 1'b0;
      end else begin
         // Held only while errored responses keep coming
         nmi_o            <= data_rvalid_i && data_err_i;
         ldst_underflow_o <= data_rvalid_i && empty;
      end
   end

   // Cause from the entry the response retires, load if none
   always_ff @(posedge rvvi) begin
      if (data_rvalid_i && data_err_i) begin
         nmi_cause_o <= (pop && store_q[rd_ptr]) ? NMI_CAUSE_STORE : NMI_CAUSE_LOAD;
      end
   end

   a_no_overflow: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      !(data_req_i && full && !data_rvalid_i));

endmodule

/* source/csr_collect.sv */
// Read select is combinational; csr_written_o only clears on reset
module csr_collect (
   input  logic                    rvvi,
   input  logic                    rst_n_i,
   input  csr_map_pkg::lane_mask_t lane_wb_i,
   input  rvfi_trace_pkg::xlen_t [csr_map_pkg::NUM_CSR_LANES-1:0] lane_value_i,
   input  csr_map_pkg::lane_idx_t  csr_rd_sel_i,
   output csr_map_pkg::lane_mask_t csr_wb_o,
   output csr_map_pkg::lane_mask_t csr_written_o,
   output rvfi_trace_pkg::xlen_t   csr_rdata_o
);

   //////////////////////////////////////////////////
   // Writeback strobes

   // Lanes already aligned with the retirement record
   assign csr_wb_o = lane_wb_i;

   // Sticky, lanes written since reset
   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         csr_written_o <= '0;
      end else begin
         csr_written_o <= csr_written_o | lane_wb_i;
      end
   end

   //////////////////////////////////////////////////
   // Read port

   assign csr_rdata_o = lane_value_i[csr_rd_sel_i];

endmodule

/* source/csr_shadow_lane.sv */
// Shadow value is only what the trace reports; hardware-side CSR changes are not seen
module csr_shadow_lane #(
   parameter csr_map_pkg::csr_addr_t LANE_ADDR   = 12'h300,
   parameter rvfi_trace_pkg::xlen_t  RESET_VALUE = '0
) (
   input  logic                  rvvi,
   input  logic                  rst_n_i,
   input  logic                  we_i,
   input  rvfi_trace_pkg::xlen_t wdata_i,
   input  rvfi_trace_pkg::xlen_t wmask_i,
   output rvfi_trace_pkg::xlen_t value_o,
   output logic                  wb_o
);
   import csr_map_pkg::*;

   // Lane address present in the package table
   function automatic logic addr_tracked(csr_addr_t addr);
      logic found;
      found = 1'b0;
      for (int i = 0; i < NUM_CSR_LANES; i++) begin
         if (csr_map_pkg::LANE_ADDR[i] == addr) begin
            found = 1'b1;
         end
      end
      return found;
   endfunction

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         value_o <= RESET_VALUE;
         wb_o    <= 1'b0;
      end else begin
         // Empty mask is no writeback
         wb_o <= we_i && (|wmask_i);
         if (we_i) begin
            value_o <= (value_o & ~wmask_i) | (wdata_i & wmask_i);
         end
      end
   end

   // Router only strobes lanes placed from the table
   a_lane_in_map: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      we_i |-> addr_tracked(LANE_ADDR));

endmodule

/* source/csr_write_route.sv */
// One CSR write per cycle; table addresses assumed unique so a hit is at most one lane
module csr_write_route (
   input  logic                   rvvi,
   input  logic                   rst_n_i,
   input  logic                   csr_we_i,
   input  csr_map_pkg::csr_addr_t csr_addr_i,
   input  rvfi_trace_pkg::xlen_t  csr_wdata_i,
   input  rvfi_trace_pkg::xlen_t  csr_wmask_i,
   // Registered lane strobe, cycle 1
   output csr_map_pkg::lane_mask_t lane_we_o,
   output rvfi_trace_pkg::xlen_t  lane_wdata_o,
   output rvfi_trace_pkg::xlen_t  lane_wmask_o,
   output logic                   csr_miss_o
);
   import csr_map_pkg::*;

   lane_mask_t hit;

   // Address compare against the lane table
   always_comb begin
      hit = '0;
      for (int i = 0; i < NUM_CSR_LANES; i++) begin
         if (csr_addr_i == LANE_ADDR[i]) begin
            hit[i] = 1'b1;
         end
      end
   end

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lane_we_o  <= '0;
         csr_miss_o <= 1'b0;
      end else begin
         lane_we_o  <= csr_we_i ? hit : '0;
         // Untracked address, no lane touched
         csr_miss_o <= csr_we_i && (hit == '0);
      end
   end

   // Write payload, only meaningful with a strobe
   always_ff @(posedge rvvi) begin
      if (csr_we_i) begin
         lane_wdata_o <= csr_wdata_i;
         lane_wmask_o <= csr_wmask_i;
      end
   end

   a_lane_onehot: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      $onehot0(lane_we_o));

endmodule

/* source/retire_stage.sv */
// Fixed 2-cycle latency, no stall; orders of successive valid records must step by one
module retire_stage (
   input  logic                      rvvi,
   input  logic                      rst_n_i,
   // RVFI retirement from the core
   input  logic                      rvfi_valid_i,
   input  rvfi_trace_pkg::order_t    rvfi_order_i,
   input  rvfi_trace_pkg::xlen_t     rvfi_insn_i,
   input  logic                      rvfi_trap_i,
   input  rvfi_trace_pkg::xlen_t     rvfi_pc_rdata_i,
   input  rvfi_trace_pkg::xlen_t     rvfi_pc_wdata_i,
   input  rvfi_trace_pkg::gpr_idx_t  rvfi_rd_addr_i,
   input  rvfi_trace_pkg::xlen_t     rvfi_rd_wdata_i,
   // RVVI state update
   output logic                      rvvi_valid_o,
   output rvfi_trace_pkg::order_t    rvvi_order_o,
   output rvfi_trace_pkg::xlen_t     rvvi_insn_o,
   output logic                      rvvi_trap_o,
   output rvfi_trace_pkg::xlen_t     rvvi_pc_rdata_o,
   output rvfi_trace_pkg::xlen_t     rvvi_pc_wdata_o,
   output rvfi_trace_pkg::gpr_mask_t rvvi_x_wb_o,
   output rvfi_trace_pkg::xlen_t     rvvi_x_wdata_o
);
   import rvfi_trace_pkg::*;

   logic      s1_valid;
   order_t    s1_order;
   xlen_t     s1_insn;
   logic      s1_trap;
   xlen_t     s1_pc_rdata;
   xlen_t     s1_pc_wdata;
   gpr_idx_t  s1_rd;
   xlen_t     s1_wdata;
   gpr_mask_t wb_mask;
   // Order tracking, only for the check below
   order_t    last_order;
   logic      seen_q;

   //////////////////////////////////////////////////
   // Stage 1 capture

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s1_valid <= 1'b0;
         seen_q   <= 1'b0;
      end else begin
         s1_valid <= rvfi_valid_i;
         // Set once the first record is out
         if (s1_valid) begin
            seen_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge rvvi) begin
      s1_order    <= rvfi_order_i;
      s1_insn     <= rvfi_insn_i;
      s1_trap     <= rvfi_trap_i;
      s1_pc_rdata <= rvfi_pc_rdata_i;
      s1_pc_wdata <= rvfi_pc_wdata_i;
      s1_rd       <= rvfi_rd_addr_i;
      s1_wdata    <= rvfi_rd_wdata_i;
      if (s1_valid) begin
         last_order <= s1_order;
      end
   end

   //////////////////////////////////////////////////
   // Stage 2 with GPR writeback decode

   // x0 is hardwired, never a writeback
   assign wb_mask = (s1_valid && (s1_rd != '0)) ? (gpr_mask_t'(1) << s1_rd) : '0;

   always_ff @(posedge rvvi or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvvi_valid_o <= 1'b0;
         rvvi_x_wb_o  <= '0;
      end else begin
         rvvi_valid_o <= s1_valid;
         rvvi_x_wb_o  <= wb_mask;
      end
   end

   always_ff @(posedge rvvi) begin
      rvvi_order_o    <= s1_order;
      rvvi_insn_o     <= s1_insn;
      rvvi_trap_o     <= s1_trap;
      rvvi_pc_rdata_o <= s1_pc_rdata;
      rvvi_pc_wdata_o <= s1_pc_wdata;
      rvvi_x_wdata_o  <= s1_wdata;
   end

   // Retirement order is gap-free across valid records, bubbles allowed
   a_order_step: assert property (@(posedge rvvi) disable iff (!rst_n_i)
      (s1_valid && seen_q) |-> (s1_order == order_t'(last_order + 1'b1)));

endmodule

/* source/csr_map_pkg.sv */
// Only eight machine/debug CSRs are shadowed; all other CSR addresses count as misses
package csr_map_pkg;

   //////////////////////////////////////////////////
   // CSR address map

   typedef logic [11:0] csr_addr_t;

   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_DCSR     = 12'h7B0;

   //////////////////////////////////////////////////
   // Shadow lanes

   localparam int unsigned NUM_CSR_LANES = 8;

   typedef logic [2:0]               lane_idx_t;
   typedef logic [NUM_CSR_LANES-1:0] lane_mask_t;

   // Lane number is the table position
   localparam csr_addr_t LANE_ADDR [NUM_CSR_LANES] = '{
      CSR_MSTATUS,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_DCSR
   };

   // mstatus comes up with MPP = M-mode
   localparam rvfi_trace_pkg::xlen_t LANE_RESET [NUM_CSR_LANES] = '{
      32'h0000_1800,
      32'h0000_0000,
      32'h0000_0000,
      32'h0000_0000,
      32'h0000_0000,
      32'h0000_0000,
      32'h0000_0000,
      32'h0000_0000
   };

endpackage

/* source/rvfi_trace_pkg.sv */
// RV32 single-hart trace widths only; the order counter is assumed never to wrap
package rvfi_trace_pkg;

   //////////////////////////////////////////////////
   // Retirement trace widths

   // Integer register file
   localparam int unsigned XLEN      = 32;
   localparam int unsigned NUM_GPR   = 32;
   localparam int unsigned GPR_IDX_W = 5;

   // RVFI order counter
   localparam int unsigned ORDER_W   = 64;

   typedef logic [XLEN-1:0]      xlen_t;
   typedef logic [GPR_IDX_W-1:0] gpr_idx_t;
   // One bit per GPR, x0 bit never set
   typedef logic [NUM_GPR-1:0]   gpr_mask_t;
   typedef logic [ORDER_W-1:0]   order_t;

   //////////////////////////////////////////////////
   // Data bus NMI causes

   // Wide enough for 1024 and 1025
   typedef logic [10:0] nmi_cause_t;

   // Load bus error
   localparam nmi_cause_t NMI_CAUSE_LOAD  = 11'd1024;
   // Store bus error
   localparam nmi_cause_t NMI_CAUSE_STORE = 11'd1025;

endpackage
